//--- source/axi_reg_consts.svh
//----------------------------------------
// widths and register count of the slave
// base address and register offsets
// register indices and the version word
//----------------------------------------
`ifndef AXI_REG_CONSTS_SVH
`define AXI_REG_CONSTS_SVH

// bus widths
`define AXI_REG_ADDR_WIDTH 32
`define AXI_REG_DATA_WIDTH 32

// register file size, control words exported to hardware
`define AXI_REG_NUM_REGS 8
`define AXI_REG_NUM_CTRL 4

// address map, registers sit one word apart from the base
`define AXI_REG_BASE_ADDR 32'h4000_0000
`define AXI_REG_STRIDE 4

// register indices past the control block
`define AXI_REG_IDX_CMD 4
`define AXI_REG_IDX_STROBE 5
`define AXI_REG_IDX_STATUS 6
`define AXI_REG_IDX_VERSION 7

// byte offsets from the base address
`define AXI_REG_OFFS_CTRL0 32'h0000_0000
`define AXI_REG_OFFS_CMD 32'h0000_0010
`define AXI_REG_OFFS_STROBE 32'h0000_0014
`define AXI_REG_OFFS_STATUS 32'h0000_0018
`define AXI_REG_OFFS_VERSION 32'h0000_001c

// constant returned by the version register
`define AXI_REG_VERSION 32'h0001_0203

`endif

//--- source/axi_reg_pkg.sv
//----------------------------------------
// response code enum
// register index and word types
// register map entry and map lookup
//----------------------------------------
`include "axi_reg_consts.svh"

package axi_reg_pkg;

    // only the two codes this slave can answer with
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    typedef logic [$clog2(`AXI_REG_NUM_REGS)-1:0] reg_id_t;
    typedef logic [`AXI_REG_DATA_WIDTH-1:0]       reg_word_t;

    // behavior flags of one register
    typedef struct packed {
        logic memory_mapped;
        logic trigger_on_write;
        logic clear_on_read;
        logic read_only_const;
    } reg_map_entry_t;

    //----------------------------------------
    // map lookup
    //----------------------------------------
    // returns the hit bit, index and entry through the output arguments
    function automatic logic reg_map_lookup(
        input  logic [`AXI_REG_ADDR_WIDTH-1:0] addr,
        output reg_id_t                        id,
        output reg_map_entry_t                 entry
    );
        logic [`AXI_REG_ADDR_WIDTH-1:0] offset;
        logic                           hit;
        offset = addr - `AXI_REG_BASE_ADDR;
        // misaligned or past the last register is unmapped
        hit    = (offset[1:0] == 2'b00) &&
                 (offset < `AXI_REG_NUM_REGS * `AXI_REG_STRIDE);
        id     = offset[$clog2(`AXI_REG_NUM_REGS)+1:2];
        entry  = '0;
        case (id)
            `AXI_REG_IDX_CMD: begin
                entry.memory_mapped    = 1'b1;
                entry.trigger_on_write = 1'b1;
            end
            // strobe keeps no storage
            `AXI_REG_IDX_STROBE:  entry.trigger_on_write = 1'b1;
            `AXI_REG_IDX_STATUS:  entry.clear_on_read    = 1'b1;
            `AXI_REG_IDX_VERSION: entry.read_only_const  = 1'b1;
            // plain control words
            default:              entry.memory_mapped    = 1'b1;
        endcase
        return hit;
    endfunction

endpackage

//--- source/reg_addr_decode.sv
//----------------------------------------
// registered address decode stage
// one instance per channel
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module reg_addr_decode
    import axi_reg_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic [`AXI_REG_ADDR_WIDTH-1:0] addr,
    output logic                           hit,
    output reg_id_t                        id,
    output reg_map_entry_t                 entry
);

    // combinational map compare, kept off the data path by the register below
    logic           lookup_hit;
    reg_id_t        lookup_id;
    reg_map_entry_t lookup_entry;

    always_comb begin
        lookup_hit = reg_map_lookup(addr, lookup_id, lookup_entry);
    end

    // hit is the only bit a channel may see outside a transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else if (load) begin
            hit <= lookup_hit;
        end
    end

    // index and flags only matter together with hit
    always_ff @(posedge clk) begin
        if (load) begin
            id    <= lookup_id;
            entry <= lookup_entry;
        end
    end

endmodule

//--- source/axi_read_channel.sv
//----------------------------------------
// AXI4-Lite read channel
// ready, fetch, valid FSM
// response select and clear-on-read request
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module axi_read_channel
    import axi_reg_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`AXI_REG_ADDR_WIDTH-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output reg_word_t                      rdata,
    output axi_resp_t                      rresp,
    output logic                           rvalid,
    input  logic                           rready,
    input  reg_word_t                      read_values [`AXI_REG_NUM_REGS],
    output logic                           clear_req,
    output reg_id_t                        clear_id
);

    localparam logic [1:0] ST_READY = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_VALID = 2'd2;

    logic [1:0]     state;
    logic [1:0]     state_next;
    logic           ar_hs;
    logic           dec_hit;
    reg_id_t        dec_id;
    reg_map_entry_t dec_entry;
    logic           is_strobe;

    assign arready = (state == ST_READY);
    assign rvalid  = (state == ST_VALID);
    assign ar_hs   = arvalid & arready;

    // address registered on the AR handshake, result ready in fetch
    reg_addr_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (ar_hs),
        .addr  (araddr),
        .hit   (dec_hit),
        .id    (dec_id),
        .entry (dec_entry)
    );

    //----------------------------------------
    // FSM
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_READY;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_READY: if (ar_hs) state_next = ST_FETCH;
            // single fetch cycle, no wait
            ST_FETCH: state_next = ST_VALID;
            ST_VALID: if (rready) state_next = ST_READY;
            default:  state_next = ST_READY;
        endcase
    end

    //----------------------------------------
    // fetch
    //----------------------------------------
    // strobe register has nothing stored behind it
    assign is_strobe = dec_entry.trigger_on_write & ~dec_entry.memory_mapped;

    // data and response held stable through the valid state
    always_ff @(posedge clk) begin
        if (state == ST_FETCH) begin
            rdata    <= (dec_hit && !is_strobe) ? read_values[dec_id] : '0;
            rresp    <= dec_hit ? RESP_OKAY : RESP_SLVERR;
            clear_id <= dec_id;
        end
    end

    // clear lands in the register file one cycle after rdata is captured
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clear_req <= 1'b0;
        end else begin
            clear_req <= (state == ST_FETCH) && dec_hit && dec_entry.clear_on_read;
        end
    end

    // read data must wait for the master
    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

//--- source/axi_write_channel.sv
//----------------------------------------
// AXI4-Lite write channel
// ready, decode, data, response FSM
// write request and trigger pulses
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module axi_write_channel
    import axi_reg_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [`AXI_REG_ADDR_WIDTH-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  reg_word_t                      wdata,
    input  logic                           wvalid,
    output logic                           wready,
    output axi_resp_t                      bresp,
    output logic                           bvalid,
    input  logic                           bready,
    output logic                           write_req,
    output reg_id_t                        write_id,
    output reg_word_t                      write_data,
    output logic [`AXI_REG_NUM_REGS-1:0]   write_trigger
);

    localparam logic [1:0] ST_READY  = 2'd0;
    localparam logic [1:0] ST_DECODE = 2'd1;
    localparam logic [1:0] ST_DATA   = 2'd2;
    localparam logic [1:0] ST_RESP   = 2'd3;

    logic [1:0]     state;
    logic [1:0]     state_next;
    logic           aw_hs;
    logic           w_hs;
    logic           dec_hit;
    reg_id_t        dec_id;
    reg_map_entry_t dec_entry;

    assign awready = (state == ST_READY);
    assign wready  = (state == ST_DATA);
    assign bvalid  = (state == ST_RESP);
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    // unmapped writes are dropped silently, so the answer is always OKAY
    assign bresp = RESP_OKAY;

    reg_addr_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (aw_hs),
        .addr  (awaddr),
        .hit   (dec_hit),
        .id    (dec_id),
        .entry (dec_entry)
    );

    //----------------------------------------
    // FSM
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_READY;
        end else begin
            state <= state_next;
        end
    end

    // wready waits for the AW handshake plus the decode cycle
    always_comb begin
        state_next = state;
        case (state)
            ST_READY:  if (aw_hs) state_next = ST_DECODE;
            ST_DECODE: state_next = ST_DATA;
            ST_DATA:   if (w_hs) state_next = ST_RESP;
            ST_RESP:   if (bready) state_next = ST_READY;
            default:   state_next = ST_READY;
        endcase
    end

    //----------------------------------------
    // write request
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (w_hs) begin
            write_id   <= dec_id;
            write_data <= wdata;
        end
    end

    // request and trigger are single-cycle pulses after the W handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_req     <= 1'b0;
            write_trigger <= '0;
        end else begin
            write_req     <= w_hs && dec_hit && dec_entry.memory_mapped;
            write_trigger <= '0;
            if (w_hs && dec_hit && dec_entry.trigger_on_write) begin
                write_trigger[dec_id] <= 1'b1;
            end
        end
    end

    // a trigger is a single line held for one cycle of the response phase
    assert property (@(posedge clk) disable iff (!rst_n)
        write_trigger != '0 |-> $onehot(write_trigger) && bvalid ##1 write_trigger == '0);

endmodule

//--- source/reg_file_store.sv
//----------------------------------------
// register storage
// write over clear arbitration
// sticky status bits and read-out
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module reg_file_store
    import axi_reg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      write_req,
    input  reg_id_t   write_id,
    input  reg_word_t write_data,
    input  logic      clear_req,
    input  reg_id_t   clear_id,
    input  reg_word_t hw_set,
    output reg_word_t read_values [`AXI_REG_NUM_REGS],
    output reg_word_t ctrl_out [`AXI_REG_NUM_CTRL]
);

    // stored words are the control block plus the command register
    localparam int NUM_STORED = `AXI_REG_IDX_CMD + 1;

    reg_word_t data_q [NUM_STORED];
    reg_word_t status_q;
    logic      status_clear;

    //----------------------------------------
    // storage
    //----------------------------------------
    // bus write beats a clear to the same word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_STORED; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_STORED; i++) begin
                if (write_req && write_id == reg_id_t'(i)) begin
                    data_q[i] <= write_data;
                end else if (clear_req && clear_id == reg_id_t'(i)) begin
                    data_q[i] <= '0;
                end
            end
        end
    end

    assign status_clear = clear_req && (clear_id == reg_id_t'(`AXI_REG_IDX_STATUS));

    // hardware set bits survive a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= (status_clear ? '0 : status_q) | hw_set;
        end
    end

    //----------------------------------------
    // read-out
    //----------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_STORED; i++) begin
            read_values[i] = data_q[i];
        end
        read_values[`AXI_REG_IDX_STROBE]  = '0;
        read_values[`AXI_REG_IDX_STATUS]  = status_q;
        // version is a constant, no flops behind it
        read_values[`AXI_REG_IDX_VERSION] = `AXI_REG_VERSION;
    end

    always_comb begin
        for (int i = 0; i < `AXI_REG_NUM_CTRL; i++) begin
            ctrl_out[i] = data_q[i];
        end
    end

    // write channel must never forward a write to status or version
    assert property (@(posedge clk) disable iff (!rst_n)
        write_req |-> (write_id != reg_id_t'(`AXI_REG_IDX_STATUS)) &&
                      (write_id != reg_id_t'(`AXI_REG_IDX_VERSION)));

endmodule

//--- source/axi_reg_slave.sv
//----------------------------------------
// AXI4-Lite register slave top level
// read and write channels, register file
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module axi_reg_slave
    import axi_reg_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    // read address and data
    input  logic [`AXI_REG_ADDR_WIDTH-1:0] araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output reg_word_t                      rdata,
    output axi_resp_t                      rresp,
    output logic                           rvalid,
    input  logic                           rready,
    // write address, data and response
    input  logic [`AXI_REG_ADDR_WIDTH-1:0] awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  reg_word_t                      wdata,
    input  logic                           wvalid,
    output logic                           wready,
    output axi_resp_t                      bresp,
    output logic                           bvalid,
    input  logic                           bready,
    // hardware side
    input  reg_word_t                      hw_set,
    output logic [`AXI_REG_NUM_REGS-1:0]   write_trigger,
    output reg_word_t                      ctrl_out [`AXI_REG_NUM_CTRL]
);

    // requests from the channels into the register file
    logic      clear_req;
    reg_id_t   clear_id;
    logic      write_req;
    reg_id_t   write_id;
    reg_word_t write_data;
    reg_word_t read_values [`AXI_REG_NUM_REGS];

    // channels run independently, one read and one write may overlap
    axi_read_channel u_read (
        .clk         (clk),
        .rst_n       (rst_n),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .read_values (read_values),
        .clear_req   (clear_req),
        .clear_id    (clear_id)
    );

    axi_write_channel u_write (
        .clk           (clk),
        .rst_n         (rst_n),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .write_req     (write_req),
        .write_id      (write_id),
        .write_data    (write_data),
        .write_trigger (write_trigger)
    );

    reg_file_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_req   (write_req),
        .write_id    (write_id),
        .write_data  (write_data),
        .clear_req   (clear_req),
        .clear_id    (clear_id),
        .hw_set      (hw_set),
        .read_values (read_values),
        .ctrl_out    (ctrl_out)
    );

endmodule

//--- test/tb_clock_gen.sv
//----------------------------------------
// free-running testbench clock
// period set by parameter, 8 ns default
//----------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // starts low so the first rising edge lands at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

//--- test/tb_axi_reg_slave.sv
//----------------------------------------
// testbench for the AXI4-Lite register slave
// register model and reference read function
// bus tasks, compare tasks, read compare process
// directed and random tests, watchdog
//----------------------------------------
`timescale 1ns/1ps
`include "axi_reg_consts.svh"

module tb_axi_reg_slave
    import axi_reg_pkg::*;
();

    // longest run is a few hundred transfers of under 20 cycles each
    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] BASE = `AXI_REG_BASE_ADDR;
    localparam reg_id_t ID_CMD = reg_id_t'(`AXI_REG_IDX_CMD);
    localparam reg_id_t ID_STROBE = reg_id_t'(`AXI_REG_IDX_STROBE);
    localparam reg_id_t ID_STATUS = reg_id_t'(`AXI_REG_IDX_STATUS);
    localparam reg_id_t ID_VERSION = reg_id_t'(`AXI_REG_IDX_VERSION);

    logic        clk;
    logic        rst_n;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    reg_word_t   rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    reg_word_t   wdata;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    reg_word_t   hw_set;
    logic [7:0]  write_trigger;
    reg_word_t   ctrl_out [`AXI_REG_NUM_CTRL];

    // register model and outstanding read expectations
    reg_word_t   model [`AXI_REG_NUM_REGS];
    reg_word_t   exp_data_q [$];
    reg_word_t   alt_data_q [$];
    axi_resp_t   exp_resp_q [$];
    int          checks;
    int          errors;
    bit          stall_en;

    tb_clock_gen u_clk (
        .clk (clk)
    );

    axi_reg_slave DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .hw_set        (hw_set),
        .write_trigger (write_trigger),
        .ctrl_out      (ctrl_out)
    );

    //----------------------------------------
    // reference model
    //----------------------------------------
    // a hit is an exact match with the address of one register
    function automatic bit decode_offset(input logic [31:0] addr, output reg_id_t id);
        bit hit;
        hit = 1'b0;
        id  = '0;
        for (int i = 0; i < `AXI_REG_NUM_REGS; i++) begin
            if (addr == BASE + 32'(4 * i)) begin
                hit = 1'b1;
                id  = reg_id_t'(i);
            end
        end
        return hit;
    endfunction

    function automatic void expected_read(input logic [31:0] addr,
                                          output reg_word_t data, output axi_resp_t resp);
        reg_id_t id;
        data = '0;
        resp = RESP_SLVERR;
        if (decode_offset(addr, id)) begin
            resp = RESP_OKAY;
            if (id == ID_VERSION) begin
                data = `AXI_REG_VERSION;
            end else if (id != ID_STROBE) begin
                data = model[id];
            end
        end
    endfunction

    // only command and strobe fire a trigger
    function automatic logic [7:0] expected_trigger(input logic [31:0] addr);
        reg_id_t id;
        expected_trigger = '0;
        if (decode_offset(addr, id) && (id == ID_CMD || id == ID_STROBE)) begin
            expected_trigger[id] = 1'b1;
        end
    endfunction

    //----------------------------------------
    // compare tasks
    //----------------------------------------
    task automatic check_word(input reg_word_t actual, input reg_word_t expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_resp(input axi_resp_t actual, input axi_resp_t expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %s, expected %s", $time, what,
                     actual.name(), expected.name());
        end
    endtask

    task automatic check_trigger(input logic [7:0] actual, input logic [7:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_ctrl_out();
        @(negedge clk);
        for (int i = 0; i < `AXI_REG_NUM_CTRL; i++) begin
            check_word(ctrl_out[i[1:0]], model[i[2:0]], "ctrl_out");
        end
    endtask

    //----------------------------------------
    // bus tasks
    //----------------------------------------
    // alt is the value that an overlapping write brings in
    task automatic read_reg(input logic [31:0] addr, input bit overlap, input reg_word_t alt);
        reg_word_t exp_data;
        axi_resp_t exp_resp;
        reg_id_t   id;
        int        stall;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        // expectation taken from the model just before the handshake edge
        expected_read(addr, exp_data, exp_resp);
        exp_data_q.push_back(exp_data);
        alt_data_q.push_back(overlap ? alt : exp_data);
        exp_resp_q.push_back(exp_resp);
        if (decode_offset(addr, id) && id == ID_STATUS) begin
            model[ID_STATUS] = '0;
        end
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        stall = stall_en ? $urandom_range(0, 3) : 0;
        repeat (stall) @(posedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input reg_word_t data);
        logic [7:0] exp_trig;
        reg_id_t    id;
        int         stall;
        exp_trig = expected_trigger(addr);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        @(negedge clk);
        while (!wready) @(negedge clk);
        @(posedge clk);
        wvalid <= 1'b0;
        // trigger high for the one cycle after the W handshake
        @(negedge clk);
        check_trigger(write_trigger, exp_trig, "write_trigger pulse");
        @(negedge clk);
        check_trigger(write_trigger, '0, "write_trigger release");
        stall = stall_en ? $urandom_range(0, 3) : 0;
        repeat (stall) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        if (!bvalid) begin
            errors++;
            $display("no write response for address %h at %0t ns", addr, $time);
        end
        check_resp(bresp, RESP_OKAY, "bresp");
        @(posedge clk);
        bready <= 1'b0;
        if (decode_offset(addr, id) && id <= ID_CMD) begin
            model[id] = data;
        end
    endtask

    // hw_set is sampled on the edge after it is driven
    task automatic pulse_hw_set(input reg_word_t bits);
        @(posedge clk);
        hw_set <= bits;
        @(posedge clk);
        hw_set <= '0;
        model[ID_STATUS] = model[ID_STATUS] | bits;
    endtask

    task automatic report_test(input int num, input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - start_errors);
        end
    endtask

    //----------------------------------------
    // read compare on every R handshake
    //----------------------------------------
    initial begin : compare_reads
        reg_word_t exp_data;
        reg_word_t alt_data;
        axi_resp_t exp_resp;
        forever begin
            @(negedge clk);
            if (rst_n && rvalid && rready) begin
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("read data returned at %0t ns with no read outstanding", $time);
                end else begin
                    exp_data = exp_data_q.pop_front();
                    alt_data = alt_data_q.pop_front();
                    exp_resp = exp_resp_q.pop_front();
                    // an overlapping write may land before or after the fetch
                    if (rdata === alt_data) begin
                        check_word(rdata, alt_data, "rdata");
                    end else begin
                        check_word(rdata, exp_data, "rdata");
                    end
                    check_resp(rresp, exp_resp, "rresp");
                end
            end
        end
    end

    //----------------------------------------
    // tests
    //----------------------------------------
    initial begin : run_tests
        int        start;
        int        idx;
        reg_word_t data;
        void'($urandom(32'hb8b9_761d));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        hw_set  = '0;
        checks   = 0;
        errors   = 0;
        stall_en = 1'b0;
        for (int i = 0; i < `AXI_REG_NUM_REGS; i++) begin
            model[i[2:0]] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // reset values of every offset
        start = errors;
        for (int i = 0; i < `AXI_REG_NUM_REGS; i++) begin
            read_reg(BASE + 4 * i, 1'b0, '0);
        end
        check_ctrl_out();
        report_test(1, "reset values", start);

        // write then read back with ready stalls in the second half
        start = errors;
        for (int n = 0; n < 24; n++) begin
            stall_en = (n >= 12);
            idx  = $urandom_range(0, 4);
            data = $urandom;
            write_reg(BASE + 4 * idx, data);
            read_reg(BASE + 4 * idx, 1'b0, '0);
        end
        check_ctrl_out();
        report_test(2, "write and read back", start);

        // trigger pulses are checked inside every write
        start = errors;
        stall_en = 1'b0;
        write_reg(BASE + 32'h10, $urandom);
        write_reg(BASE + 32'h14, 32'hffff_ffff);
        write_reg(BASE + 32'h08, $urandom);
        read_reg(BASE + 32'h14, 1'b0, '0);
        read_reg(BASE + 32'h10, 1'b0, '0);
        report_test(3, "write triggers", start);

        // sticky status and clear-on-read
        start = errors;
        pulse_hw_set(32'h0000_0001);
        pulse_hw_set(32'h0000_0100);
        read_reg(BASE + 32'h18, 1'b0, '0);
        read_reg(BASE + 32'h18, 1'b0, '0);
        pulse_hw_set(32'h8000_0000);
        read_reg(BASE + 32'h18, 1'b0, '0);
        read_reg(BASE + 32'h18, 1'b0, '0);
        report_test(4, "status clear-on-read", start);

        // unmapped and misaligned offsets and ignored writes
        start = errors;
        read_reg(BASE + 32'h20, 1'b0, '0);
        read_reg(BASE + 32'h02, 1'b0, '0);
        read_reg(BASE + 32'h1d, 1'b0, '0);
        read_reg(BASE - 32'h04, 1'b0, '0);
        read_reg(32'h0000_0000, 1'b0, '0);
        write_reg(BASE + 32'h20, $urandom);
        write_reg(BASE + 32'h18, $urandom);
        write_reg(BASE + 32'h1c, $urandom);
        write_reg(BASE + 32'h01, $urandom);
        for (int i = 0; i < `AXI_REG_NUM_REGS; i++) begin
            read_reg(BASE + 4 * i, 1'b0, '0);
        end
        check_ctrl_out();
        report_test(5, "unmapped access", start);

        // read and write in flight together
        start = errors;
        stall_en = 1'b1;
        for (int n = 0; n < 8; n++) begin
            idx  = $urandom_range(0, 4);
            data = $urandom;
            fork
                read_reg(BASE + 4 * idx, 1'b1, data);
                write_reg(BASE + 4 * idx, data);
            join
            read_reg(BASE + 4 * idx, 1'b0, '0);
        end
        check_ctrl_out();
        report_test(6, "overlapping read and write", start);

        repeat (4) @(posedge clk);
        if (exp_data_q.size() != 0) begin
            errors++;
            $display("%0d reads never returned data", exp_data_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    //----------------------------------------
    // watchdog
    //----------------------------------------
    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/axi_reg_pkg.sv
source/reg_addr_decode.sv
source/axi_read_channel.sv
source/axi_write_channel.sv
source/reg_file_store.sv
source/axi_reg_slave.sv
test/tb_clock_gen.sv
test/tb_axi_reg_slave.sv

//--- Makefile
# Verilator flow for the AXI4-Lite register slave
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= tb_axi_reg_slave
RTL_TOP   ?= axi_reg_slave
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TESTBENCH FAILED
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# fails when the log holds the fail message or the run exits with an error
sim: build
	@./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
